/* tb.f */
verilog/bank_xbar_pkg.sv
verilog/bank_arbiter.sv
verilog/xbar_control.sv
verilog/onehot_xbar.sv
verilog/mem_bank.sv
verilog/banked_mem_xbar.sv
verif/clock_gen.sv
verif/xbar_checker.sv
verif/banked_mem_xbar_tb.sv

/* verif/banked_mem_xbar_tb.sv */
// Banked scratchpad testbench
`timescale 1ns/1ps
`default_nettype none

module banked_mem_xbar_tb
  import bank_xbar_pkg::*;
();

  localparam int ports_lp       = 4;
  localparam int retry_limit_lp = 16;

  // one row is one cycle of requests on all ports
  typedef struct packed {
    logic [3:0]                test_id;
    logic                      check_acc;
    logic      [ports_lp-1:0]  v;
    logic      [ports_lp-1:0]  acc;
    port_req_t [ports_lp-1:0]  req;
  } row_t;

  logic                     clk;
  logic                     reset;
  logic      [ports_lp-1:0] req_v;
  port_req_t [ports_lp-1:0] req;
  logic      [ports_lp-1:0] yumi;
  logic      [ports_lp-1:0] rsp_v;
  word_t     [ports_lp-1:0] rsp_data;

  int   chk_errors;
  int   chk_checks;
  int   tb_errors;
  int   tb_checks;
  int   err_mark;
  int   tests_run;
  bit   timed_out;
  row_t table_q[$];

  string test_names [7] = '{
    "arbitration after reset",
    "fill all banks",
    "parallel writes and reads",
    "byte-masked writes",
    "read contention rotation",
    "write then held read",
    "random traffic"
  };

  clock_gen i_clock_gen (
    .clk_o   (clk),
    .reset_o (reset)
  );

  banked_mem_xbar #(
    .arb_policy_p (ARB_ROUND_ROBIN)
  ) i_banked_mem_xbar (
    .clk_i      (clk),
    .reset_i    (reset),
    .req_v_i    (req_v),
    .req_i      (req),
    .req_yumi_o (yumi),
    .rsp_v_o    (rsp_v),
    .rsp_data_o (rsp_data)
  );

  xbar_checker i_xbar_checker (
    .clk_i      (clk),
    .reset_i    (reset),
    .req_v_i    (req_v),
    .req_i      (req),
    .req_yumi_i (yumi),
    .rsp_v_i    (rsp_v),
    .rsp_data_i (rsp_data),
    .errors_o   (chk_errors),
    .checks_o   (chk_checks)
  );

  function automatic word_t fill_word(addr_t a);
    return {a ^ 16'hc3a5, ~a};
  endfunction

  function automatic void open_row(int test_id, logic check_acc);
    row_t r;
    r           = '0;
    r.test_id   = 4'(test_id);
    r.check_acc = check_acc;
    table_q.push_back(r);
  endfunction

  function automatic void put_req(int p, logic we, addr_t a, word_t d, mask_t m, logic acc);
    row_t r;
    r        = table_q[table_q.size()-1];
    r.v[p]   = 1'b1;
    r.acc[p] = acc;
    r.req[p] = {we, a, d, m};
    table_q[table_q.size()-1] = r;
  endfunction

  // address is bank * 16 + word index
  function automatic void build_table();
    open_row(0, 1'b1);
    for (int p = 0; p < ports_lp; p++)
      put_req(p, 1'b1, addr_t'(32 + p), fill_word(addr_t'(32 + p)), 4'hf, p == 0);
    open_row(0, 1'b1);
    for (int p = 0; p < ports_lp; p++)
      put_req(p, 1'b0, addr_t'(32 + p), '0, '0, p == 0);
    for (int i = 0; i < 16; i++)
    begin
      open_row(1, 1'b1);
      for (int p = 0; p < ports_lp; p++)
        put_req(p, 1'b1, addr_t'(16*p + i), fill_word(addr_t'(16*p + i)), 4'hf, 1'b1);
    end
    open_row(2, 1'b1);
    for (int p = 0; p < ports_lp; p++)
      put_req(p, 1'b1, addr_t'(17*p + 8), 32'hc0de_0000 + p, 4'hf, 1'b1);
    open_row(2, 1'b1);
    for (int p = 0; p < ports_lp; p++)
      put_req(p, 1'b0, addr_t'(17*p + 8), '0, '0, 1'b1);
    open_row(3, 1'b1);
    put_req(0, 1'b1, 16'h05, 32'h1122_3344, 4'b0101, 1'b1);
    put_req(2, 1'b1, 16'h27, 32'hdead_beef, 4'b1000, 1'b1);
    open_row(3, 1'b1);
    put_req(0, 1'b0, 16'h05, '0, '0, 1'b1);
    put_req(2, 1'b0, 16'h27, '0, '0, 1'b1);
    // bank 1 last went to port 1, so port 2 leads
    open_row(4, 1'b1);
    for (int p = 0; p < ports_lp; p++)
      put_req(p, 1'b0, addr_t'(16 + p), '0, '0, p == 2);
    open_row(4, 1'b1);
    put_req(0, 1'b0, 16'h02, '0, '0, 1'b0);
    put_req(1, 1'b0, 16'h03, '0, '0, 1'b1);
    put_req(2, 1'b0, 16'h3a, '0, '0, 1'b1);
    put_req(3, 1'b0, 16'h3b, '0, '0, 1'b0);
    open_row(5, 1'b1);
    put_req(0, 1'b1, 16'h31, 32'hfeed_f00d, 4'hf, 1'b1);
    put_req(1, 1'b0, 16'h31, '0, '0, 1'b0);
    for (int i = 0; i < 24; i++)
    begin
      open_row(6, 1'b0);
      for (int p = 0; p < ports_lp; p++)
        if ($urandom_range(3, 0) != 0)
          put_req(p, 1'($urandom_range(1, 0)), addr_t'($urandom_range(63, 0)),
                  word_t'($urandom), mask_t'($urandom_range(15, 0)), 1'b0);
    end
  endfunction

  task automatic wait_reset_done();
    int waited;
    waited = 0;
    while (reset !== 1'b0 && !timed_out)
    begin
      @(posedge clk);
      waited++;
      if (waited > 20)
      begin
        $display("reset was still high after %0d cycles", waited);
        timed_out = 1'b1;
      end
    end
  endtask

  task automatic apply_row(input row_t r);
    logic [ports_lp-1:0] pend;
    int tries;
    pend  = r.v;
    tries = 0;
    @(posedge clk);
    req   <= r.req;
    req_v <= pend;
    @(negedge clk);
    if (r.check_acc)
    begin
      tb_checks++;
      if ((yumi & pend) !== r.acc)
      begin
        tb_errors++;
        $display("FAILED at %0t ns: req_yumi_o expected %b actual %b", $time, r.acc, yumi & pend);
      end
    end
    pend = pend & ~yumi;
    while (pend != '0 && !timed_out)
    begin
      tries++;
      if (tries > retry_limit_lp)
      begin
        $display("ports %b were never accepted after %0d retries", pend, retry_limit_lp);
        timed_out = 1'b1;
      end
      else
      begin
        // refused ports keep the same request
        @(posedge clk);
        req_v <= pend;
        @(negedge clk);
        pend = pend & ~yumi;
      end
    end
  endtask

  // one idle cycle lets the last read response be checked
  task automatic close_test(input int id);
    int errs;
    @(posedge clk);
    req_v <= '0;
    @(negedge clk);
    @(posedge clk);
    errs = tb_errors + chk_errors - err_mark;
    err_mark = tb_errors + chk_errors;
    tests_run++;
    $display("test %0d (%s) finished with %0d errors", id, test_names[id], errs);
  endtask

  initial
  begin
    req_v     = '0;
    req       = '0;
    tb_errors = 0;
    tb_checks = 0;
    err_mark  = 0;
    tests_run = 0;
    timed_out = 1'b0;
    void'($urandom(82839));
    build_table();
    wait_reset_done();
    for (int i = 0; i < table_q.size() && !timed_out; i++)
    begin
      if (i > 0 && table_q[i].test_id != table_q[i-1].test_id)
        close_test(table_q[i-1].test_id);
      apply_row(table_q[i]);
    end
    if (!timed_out)
      close_test(table_q[table_q.size()-1].test_id);
    $display("tests %0d, checks %0d, errors %0d", tests_run, tb_checks + chk_checks,
             tb_errors + chk_errors);
    if (!timed_out && tb_errors + chk_errors == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

endmodule : banked_mem_xbar_tb

`default_nettype wire

/* verif/xbar_checker.sv */
// Crossbar response checker
`timescale 1ns/1ps
`default_nettype none

module xbar_checker
  import bank_xbar_pkg::*;
#(
  parameter int num_ports_p  = 4,
  parameter int num_banks_p  = 4,
  parameter int bank_words_p = 16
)
(
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  logic      [num_ports_p-1:0] req_v_i,
  input  port_req_t [num_ports_p-1:0] req_i,
  input  logic      [num_ports_p-1:0] req_yumi_i,
  input  logic      [num_ports_p-1:0] rsp_v_i,
  input  word_t     [num_ports_p-1:0] rsp_data_i,
  output int                          errors_o,
  output int                          checks_o
);

  // last winner per bank for the round robin model
  int    last_win [num_banks_p];
  word_t model_mem [num_banks_p*bank_words_p];
  logic  [num_ports_p-1:0] exp_v;
  word_t [num_ports_p-1:0] exp_data;

  initial
  begin
    errors_o = 0;
    checks_o = 0;
    exp_v    = '0;
  end

  task automatic compare(input string name, input int port,
                         input word_t exp, input word_t act);
    checks_o++;
    if (act !== exp)
    begin
      errors_o++;
      $display("FAILED at %0t ns: %s[%0d] expected %h actual %h", $time, name, port, exp, act);
    end
  endtask

  // inputs change on the rising edge so sample on the falling edge
  always @(negedge clk_i)
  begin
    logic [num_ports_p-1:0] exp_yumi;
    int cand;
    int won;
    int slot;

    if (reset_i !== 1'b0)
    begin
      for (int b = 0; b < num_banks_p; b++)
        last_win[b] = num_ports_p - 1;
      exp_v = '0;
    end
    else
    begin
      // responses owed for reads taken at the last edge
      for (int p = 0; p < num_ports_p; p++)
      begin
        compare("rsp_v_o", p, word_t'(exp_v[p]), word_t'(rsp_v_i[p]));
        if (exp_v[p])
          compare("rsp_data_o", p, exp_data[p], rsp_data_i[p]);
      end
      // first requester after the last winner gets the bank
      exp_yumi = '0;
      for (int b = 0; b < num_banks_p; b++)
      begin
        won = -1;
        for (int k = 1; k <= num_ports_p; k++)
        begin
          cand = (last_win[b] + k) % num_ports_p;
          if (won < 0 && req_v_i[cand]
              && (int'(req_i[cand].addr) / bank_words_p) % num_banks_p == b)
            won = cand;
        end
        if (won >= 0)
        begin
          exp_yumi[won] = 1'b1;
          last_win[b]   = won;
        end
      end
      for (int p = 0; p < num_ports_p; p++)
        compare("req_yumi_o", p, word_t'(exp_yumi[p]), word_t'(req_yumi_i[p]));
      // memory model follows the predicted accepts
      for (int p = 0; p < num_ports_p; p++)
      begin
        slot        = int'(req_i[p].addr) % (num_banks_p * bank_words_p);
        exp_v[p]    = exp_yumi[p] && !req_i[p].we;
        exp_data[p] = model_mem[slot];
        if (exp_yumi[p] && req_i[p].we)
          for (int j = 0; j < mask_width_c; j++)
            if (req_i[p].mask[j])
              model_mem[slot][8*j +: 8] = req_i[p].wdata[8*j +: 8];
      end
    end
  end

endmodule : xbar_checker

`default_nettype wire

/* verif/clock_gen.sv */
// Testbench clock and reset
`timescale 1ns/1ps
`default_nettype none

module clock_gen
(
  output logic clk_o,
  output logic reset_o
);

  // 40 ns period, reset is raised before the first edge
  initial
  begin
    reset_o = 1'b1;
    clk_o   = 1'b0;
    forever #20 clk_o = ~clk_o;
  end

  // release after five rising edges
  initial
  begin
    repeat (5) @(posedge clk_o);
    reset_o <= 1'b0;
  end

endmodule : clock_gen

`default_nettype wire

/* verilog/banked_mem_xbar.sv */
// Multi-port banked scratchpad
`timescale 1ns/1ps
`default_nettype none

module banked_mem_xbar
  import bank_xbar_pkg::*;
#(
  parameter int          num_ports_p  = 4,
  parameter int          num_banks_p  = 4,
  parameter int          bank_words_p = 16,
  parameter arb_policy_e arb_policy_p = ARB_ROUND_ROBIN
)
(
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  logic      [num_ports_p-1:0] req_v_i,
  input  port_req_t [num_ports_p-1:0] req_i,
  output logic      [num_ports_p-1:0] req_yumi_o,
  output logic      [num_ports_p-1:0] rsp_v_o,
  output word_t     [num_ports_p-1:0] rsp_data_o
);

  addr_t [num_ports_p-1:0] req_addr;

  logic [num_banks_p-1:0][num_ports_p-1:0] bank_grant;
  logic [num_banks_p-1:0][num_ports_p-1:0] bank_grant_r;
  logic [num_ports_p-1:0][num_banks_p-1:0] port_grant;
  logic [num_banks_p-1:0]                  bank_v;
  logic [num_banks_p-1:0]                  bank_rd_r;

  port_req_t [num_banks_p-1:0] bank_req;
  word_t     [num_banks_p-1:0] bank_rdata;

  for (genvar p = 0; p < num_ports_p; p++)
  begin : g_addr
    assign req_addr[p] = req_i[p].addr;
  end

  xbar_control #(
    .num_ports_p  (num_ports_p),
    .num_banks_p  (num_banks_p),
    .bank_words_p (bank_words_p),
    .arb_policy_p (arb_policy_p)
  ) i_xbar_control (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .req_v_i      (req_v_i),
    .req_addr_i   (req_addr),
    .yumi_o       (req_yumi_o),
    .bank_v_o     (bank_v),
    .bank_grant_o (bank_grant)
  );

  // winning request of each bank
  onehot_xbar #(
    .num_in_p  (num_ports_p),
    .num_out_p (num_banks_p),
    .payload_t (port_req_t)
  ) req_xbar (
    .in_i  (req_i),
    .sel_i (bank_grant),
    .out_o (bank_req)
  );

  for (genvar b = 0; b < num_banks_p; b++)
  begin : g_bank
    mem_bank #(
      .bank_words_p (bank_words_p)
    ) i_mem_bank (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .v_i     (bank_v[b]),
      .req_i   (bank_req[b]),
      .rdata_o (bank_rdata[b])
    );
  end

  // remember who read from which bank for the return cycle
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      bank_grant_r <= '0;
      bank_rd_r    <= '0;
    end
    else
    begin
      bank_grant_r <= bank_grant;
      for (int b = 0; b < num_banks_p; b++)
      begin
        bank_rd_r[b] <= bank_v[b] & ~bank_req[b].we;
      end
    end
  end

  // port-by-bank view of the registered grant
  always_comb
  begin
    for (int p = 0; p < num_ports_p; p++)
    begin
      for (int b = 0; b < num_banks_p; b++)
      begin
        port_grant[p][b] = bank_grant_r[b][p];
      end
    end
  end

  onehot_xbar #(
    .num_in_p  (num_banks_p),
    .num_out_p (num_ports_p),
    .payload_t (word_t)
  ) rsp_xbar (
    .in_i  (bank_rdata),
    .sel_i (port_grant),
    .out_o (rsp_data_o)
  );

  // read valid follows the same select as the data
  always_comb
  begin
    for (int p = 0; p < num_ports_p; p++)
    begin
      rsp_v_o[p] = |(port_grant[p] & bank_rd_r);
    end
  end

endmodule : banked_mem_xbar

`default_nettype wire

/* verilog/mem_bank.sv */
// Single-port byte-masked memory bank
`timescale 1ns/1ps
`default_nettype none

module mem_bank
  import bank_xbar_pkg::*;
#(
  parameter int bank_words_p = 16
)
(
  input  logic      clk_i,
  input  logic      reset_i,
  input  logic      v_i,
  input  port_req_t req_i,
  output word_t     rdata_o
);

  localparam int index_width_lp = (bank_words_p > 1) ? $clog2(bank_words_p) : 1;

  word_t mem_r [bank_words_p];

  logic [index_width_lp-1:0] index;

  // low address bits pick the word inside the bank
  assign index = req_i.addr[index_width_lp-1:0];

  // accesses are ignored while in reset
  always_ff @(posedge clk_i)
  begin
    if (v_i && !reset_i)
    begin
      if (req_i.we)
      begin
        for (int j = 0; j < mask_width_c; j++)
        begin
          if (req_i.mask[j])
          begin
            mem_r[index][8*j +: 8] <= req_i.wdata[8*j +: 8];
          end
        end
      end
      else
      begin
        // read data holds until the next read
        rdata_o <= mem_r[index];
      end
    end
  end

endmodule : mem_bank

`default_nettype wire

/* verilog/onehot_xbar.sv */
// One-hot select crossbar
`timescale 1ns/1ps
`default_nettype none

module onehot_xbar #(
  parameter int  num_in_p  = 4,
  parameter int  num_out_p = 4,
  parameter type payload_t = logic [31:0]
)
(
  input  payload_t [num_in_p-1:0]                in_i,
  input  logic     [num_out_p-1:0][num_in_p-1:0] sel_i,
  output payload_t [num_out_p-1:0]               out_o
);

  localparam int width_lp = $bits(payload_t);

  // and-or mux per output, empty row gives zero
  always_comb
  begin
    logic [width_lp-1:0] acc;

    for (int o = 0; o < num_out_p; o++)
    begin
      acc = '0;
      for (int i = 0; i < num_in_p; i++)
      begin
        acc = acc | ({width_lp{sel_i[o][i]}} & width_lp'(in_i[i]));
      end
      out_o[o] = payload_t'(acc);
    end
  end

endmodule : onehot_xbar

`default_nettype wire

/* verilog/xbar_control.sv */
// Crossbar bank arbitration control
`timescale 1ns/1ps
`default_nettype none

module xbar_control
  import bank_xbar_pkg::*;
#(
  parameter int          num_ports_p  = 4,
  parameter int          num_banks_p  = 4,
  parameter int          bank_words_p = 16,
  parameter arb_policy_e arb_policy_p = ARB_ROUND_ROBIN
)
(
  input  logic                                    clk_i,
  input  logic                                    reset_i,
  input  logic  [num_ports_p-1:0]                 req_v_i,
  input  addr_t [num_ports_p-1:0]                 req_addr_i,
  output logic  [num_ports_p-1:0]                 yumi_o,
  output logic  [num_banks_p-1:0]                 bank_v_o,
  output logic  [num_banks_p-1:0][num_ports_p-1:0] bank_grant_o
);

  localparam int index_width_lp = (bank_words_p > 1) ? $clog2(bank_words_p) : 1;
  localparam int bank_sel_lp    = (num_banks_p > 1) ? $clog2(num_banks_p) : 1;

  logic [num_ports_p-1:0][bank_sel_lp-1:0] bank_num;
  logic [num_banks_p-1:0][num_ports_p-1:0] bank_reqs;

  // bank number comes from the bits just above the word index
  always_comb
  begin
    for (int p = 0; p < num_ports_p; p++)
    begin
      if (num_banks_p > 1)
        bank_num[p] = req_addr_i[p][index_width_lp +: bank_sel_lp];
      else
        bank_num[p] = '0;
    end
  end

  // one-hot request rows, one row per bank
  always_comb
  begin
    for (int b = 0; b < num_banks_p; b++)
    begin
      for (int p = 0; p < num_ports_p; p++)
      begin
        bank_reqs[b][p] = req_v_i[p] && (bank_num[p] == bank_sel_lp'(b));
      end
    end
  end

  for (genvar b = 0; b < num_banks_p; b++)
  begin : g_arb
    bank_arbiter #(
      .num_ports_p  (num_ports_p),
      .arb_policy_p (arb_policy_p)
    ) i_bank_arbiter (
      .clk_i    (clk_i),
      .reset_i  (reset_i),
      .reqs_i   (bank_reqs[b]),
      .grants_o (bank_grant_o[b])
    );

    assign bank_v_o[b] = |bank_grant_o[b];
  end

  // a port is accepted when any bank granted it
  always_comb
  begin
    logic hit;

    for (int p = 0; p < num_ports_p; p++)
    begin
      hit = 1'b0;
      for (int b = 0; b < num_banks_p; b++)
      begin
        hit = hit | bank_grant_o[b][p];
      end
      yumi_o[p] = req_v_i[p] & hit;
    end
  end

endmodule : xbar_control

`default_nettype wire

/* verilog/bank_arbiter.sv */
// Per-bank request arbiter
`timescale 1ns/1ps
`default_nettype none

module bank_arbiter
  import bank_xbar_pkg::*;
#(
  parameter int          num_ports_p  = 4,
  parameter arb_policy_e arb_policy_p = ARB_ROUND_ROBIN
)
(
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  logic [num_ports_p-1:0] reqs_i,
  output logic [num_ports_p-1:0] grants_o
);

  localparam int ptr_width_lp = (num_ports_p > 1) ? $clog2(num_ports_p) : 1;

  // last granted port, only meaningful for round robin
  logic [ptr_width_lp-1:0] last_r;
  logic [ptr_width_lp-1:0] last_n;

  // search order depends on the policy, first requester in order wins
  always_comb
  begin
    int   idx;
    logic found;

    grants_o = '0;
    last_n   = last_r;
    found    = 1'b0;
    idx      = 0;

    for (int k = 0; k < num_ports_p; k++)
    begin
      case (arb_policy_p)
        ARB_FIXED_LO:
        begin
          idx = k;
        end
        ARB_FIXED_HI:
        begin
          idx = num_ports_p - 1 - k;
        end
        default:
        begin
          // start just after the last winner and wrap
          idx = int'(last_r) + 1 + k;
          if (idx >= num_ports_p)
          begin
            idx = idx - num_ports_p;
          end
        end
      endcase

      if (!found && reqs_i[idx])
      begin
        found         = 1'b1;
        grants_o[idx] = 1'b1;
        last_n        = idx[ptr_width_lp-1:0];
      end
    end
  end

  // pointer starts at the top port so port 0 has first priority
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      last_r <= ptr_width_lp'(num_ports_p - 1);
    end
    else if (|grants_o)
    begin
      last_r <= last_n;
    end
  end

endmodule : bank_arbiter

`default_nettype wire

/* verilog/bank_xbar_pkg.sv */
// Banked scratchpad shared types
`default_nettype none

package bank_xbar_pkg;

  // word and address geometry
  localparam int word_width_c = 32;
  localparam int mask_width_c = word_width_c / 8;
  localparam int addr_width_c = 16;

  // one data word
  typedef logic [word_width_c-1:0] word_t;

  // byte write enables, 1 means the byte is written
  typedef logic [mask_width_c-1:0] mask_t;

  // word address, bank number sits just above the in-bank index
  typedef logic [addr_width_c-1:0] addr_t;

  // one port request as it travels from a port to a bank
  typedef struct packed {
    logic  we;
    addr_t addr;
    word_t wdata;
    mask_t mask;
  } port_req_t;

  // per-bank arbitration policy
  typedef enum logic [1:0] {
    ARB_FIXED_LO    = 2'd0,
    ARB_FIXED_HI    = 2'd1,
    ARB_ROUND_ROBIN = 2'd2
  } arb_policy_e;

endpackage : bank_xbar_pkg

`default_nettype wire
